/* logic/dma_pkg.sv */
// Shared widths and types; addresses are byte based and word aligned, lengths count 32-bit words
package dma_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------

    // Byte address width on the source bus
    localparam int unsigned ADDR_W = 24;

    // One data word on Wishbone, in the buffer and on the stream
    localparam int unsigned DATA_W = 32;

    // Word count of a single request
    localparam int unsigned LEN_W = 16;

    // Address stride between consecutive source words
    localparam int unsigned WORD_BYTES = DATA_W / 8;

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------

    // Source and Wishbone byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // Payload word
    typedef logic [DATA_W-1:0] data_t;

    // Request length and remaining counters
    typedef logic [LEN_W-1:0] len_t;

    // ----------------------------------------------------------
    // Reader FSM
    // ----------------------------------------------------------

    // WAIT_SPACE doubles as the release cycle after each ack
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT_SPACE
    } rd_state_e;

endpackage

/* logic/dma_req_gate.sv */
// One transfer at a time; zero lengths answered with an error and no bus or stream activity
`timescale 1ns/1ns

module dma_req_gate
    import dma_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Request handshake
    input  logic  req_valid_i,
    input  addr_t req_src_addr_i,
    input  len_t  req_len_i,
    output logic  req_ready_o,
    // Response handshake
    output logic  rsp_valid_o,
    output logic  rsp_error_o,
    input  logic  rsp_ready_i,
    // Transfer launch towards reader and writer
    output logic  start_o,
    output addr_t base_addr_o,
    output len_t  word_count_o,
    // Completion from the writer
    input  logic  done_i,
    output logic  busy_o
);

    typedef enum logic [1:0] {
        GATE_IDLE,
        GATE_ACTIVE,
        GATE_RESPOND
    } gate_state_e;

    gate_state_e state_q;
    logic        rsp_error_q;
    logic        req_fire;
    logic        len_zero;

    // Only idle with no response pending may take a request
    assign req_ready_o = (state_q == GATE_IDLE);
    assign req_fire    = req_valid_i && req_ready_o;
    assign len_zero    = (req_len_i == '0);

    // Launch in the acceptance cycle so the reader strobes one cycle later
    assign start_o      = req_fire && !len_zero;
    assign base_addr_o  = req_src_addr_i;
    assign word_count_o = req_len_i;

    assign rsp_valid_o = (state_q == GATE_RESPOND);
    assign rsp_error_o = rsp_error_q;
    assign busy_o      = (state_q != GATE_IDLE);

    // ----------------------------------------------------------
    // Gate FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= GATE_IDLE;
            rsp_error_q <= 1'b0;
        end else begin
            case (state_q)
                GATE_IDLE: begin
                    if (req_fire) begin
                        // Zero length skips the datapath entirely
                        state_q     <= len_zero ? GATE_RESPOND : GATE_ACTIVE;
                        rsp_error_q <= len_zero;
                    end
                end
                GATE_ACTIVE: begin
                    // Writer saw the last beat go out
                    if (done_i) begin
                        state_q     <= GATE_RESPOND;
                        rsp_error_q <= 1'b0;
                    end
                end
                GATE_RESPOND: begin
                    if (rsp_ready_i) begin
                        state_q <= GATE_IDLE;
                    end
                end
                default: state_q <= GATE_IDLE;
            endcase
        end
    end

    // Writer completion only ever lands on a running transfer
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |-> state_q == GATE_ACTIVE);

endmodule

/* logic/dma_wb_reader.sv */
// Wishbone classic read-only master; one word per bus cycle, low two address bits forced to zero
`timescale 1ns/1ns

module dma_wb_reader
    import dma_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Launch from the gate
    input  logic  start_i,
    input  addr_t base_addr_i,
    input  len_t  word_count_i,
    // Wishbone master side
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output addr_t wb_adr_o,
    input  data_t wb_dat_i,
    input  logic  wb_ack_i,
    // Buffer write port
    output logic  buf_push_o,
    output data_t buf_data_o,
    input  logic  buf_not_full_i
);

    rd_state_e state_q;
    addr_t     addr_q;
    len_t      remaining_q;
    logic      last_word;

    // Bus cycle lives exactly as long as the READ state
    assign wb_cyc_o = (state_q == READ);
    assign wb_stb_o = (state_q == READ);
    assign wb_adr_o = addr_q;

    // Ack data goes straight into the buffer on the same edge
    assign buf_push_o = (state_q == READ) && wb_ack_i;
    assign buf_data_o = wb_dat_i;

    assign last_word = (remaining_q == len_t'(1));

    // ----------------------------------------------------------
    // Reader FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            addr_q      <= '0;
            remaining_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        // Byte offset bits dropped, sources are word aligned
                        addr_q      <= base_addr_i & ~addr_t'(WORD_BYTES - 1);
                        remaining_q <= word_count_i;
                        state_q     <= buf_not_full_i ? READ : WAIT_SPACE;
                    end
                end
                READ: begin
                    // Address and strobe held until the slave answers
                    if (wb_ack_i) begin
                        addr_q      <= addr_q + addr_t'(WORD_BYTES);
                        remaining_q <= remaining_q - len_t'(1);
                        // Strobe drops after every ack
                        state_q     <= last_word ? IDLE : WAIT_SPACE;
                    end
                end
                WAIT_SPACE: begin
                    // Also waits out a full buffer
                    if (buf_not_full_i) begin
                        state_q <= READ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

/* logic/dma_beat_buffer.sv */
// Circular FIFO with comb head output; BufferDepth must be 2 or more, push and pop may coincide
`timescale 1ns/1ns

module dma_beat_buffer
    import dma_pkg::*;
#(
    parameter int unsigned BufferDepth = 4
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Write side, from the reader
    input  logic  push_i,
    input  data_t push_data_i,
    output logic  not_full_o,
    // Read side, to the writer
    input  logic  pop_i,
    output data_t pop_data_o,
    output logic  not_empty_o
);

    localparam int unsigned PtrW = $clog2(BufferDepth);
    localparam int unsigned CntW = $clog2(BufferDepth + 1);

    typedef logic [PtrW-1:0] ptr_t;
    typedef logic [CntW-1:0] cnt_t;

    data_t mem_q [BufferDepth];
    ptr_t  wr_ptr_q;
    ptr_t  rd_ptr_q;
    cnt_t  count_q;

    // Wrap at the depth, which need not be a power of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        ptr_t nxt;
        if (ptr == ptr_t'(BufferDepth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + ptr_t'(1);
        end
        return nxt;
    endfunction

    assign not_full_o  = (count_q != cnt_t'(BufferDepth));
    assign not_empty_o = (count_q != '0);

    // Head word visible without a read cycle
    assign pop_data_o = mem_q[rd_ptr_q];

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + cnt_t'(1);
                2'b01:   count_q <= count_q - cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // Reader must respect the full flag
    assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> not_full_o);

    // Writer must respect the empty flag
    assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> not_empty_o);

endmodule

/* logic/dma_stream_writer.sv */
// Valid/ready stream source; last marks the final word, done pulses the cycle after it is taken
`timescale 1ns/1ns

module dma_stream_writer
    import dma_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Launch from the gate
    input  logic  start_i,
    input  len_t  word_count_i,
    // Buffer read port
    output logic  buf_pop_o,
    input  data_t buf_data_i,
    input  logic  buf_not_empty_i,
    // Stream output
    output logic  st_valid_o,
    output data_t st_data_o,
    output logic  st_last_o,
    input  logic  st_ready_i,
    // Completion towards the gate
    output logic  done_o
);

    logic active_q;
    logic done_q;
    len_t remaining_q;
    logic beat_fire;
    logic last_beat;

    // Buffer head shown directly as the beat
    assign st_valid_o = active_q && buf_not_empty_i;
    assign st_data_o  = buf_data_i;

    assign last_beat = (remaining_q == len_t'(1));
    assign st_last_o = st_valid_o && last_beat;

    // Handshake pops the head
    assign beat_fire = st_valid_o && st_ready_i;
    assign buf_pop_o = beat_fire;

    assign done_o = done_q;

    // ----------------------------------------------------------
    // Beat counter
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q    <= 1'b0;
            done_q      <= 1'b0;
            remaining_q <= '0;
        end else begin
            // Single cycle pulse
            done_q <= 1'b0;
            if (start_i) begin
                active_q    <= 1'b1;
                remaining_q <= word_count_i;
            end else if (beat_fire) begin
                remaining_q <= remaining_q - len_t'(1);
                if (last_beat) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end
            end
        end
    end

    // Between transfers the buffer stays empty
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !active_q |-> !buf_not_empty_i);

    // A beat never shows up with its count already used up
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(st_valid_o) |-> remaining_q != '0);

endmodule

/* logic/dma_backend_top.sv */
// 1D copy engine, Wishbone classic source to valid/ready stream; word aligned, one transfer at a time
`timescale 1ns/1ns

module dma_backend_top
    import dma_pkg::*;
#(
    parameter int unsigned BufferDepth = 4
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    // Request
    input  logic  req_valid_i,
    output logic  req_ready_o,
    input  addr_t req_src_addr_i,
    input  len_t  req_len_i,
    // Response
    output logic  rsp_valid_o,
    output logic  rsp_error_o,
    input  logic  rsp_ready_i,
    // Wishbone read master
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output addr_t wb_adr_o,
    input  data_t wb_dat_i,
    input  logic  wb_ack_i,
    // Stream out
    output logic  st_valid_o,
    output data_t st_data_o,
    output logic  st_last_o,
    input  logic  st_ready_i,
    // Status
    output logic  busy_o
);

    // Launch and completion
    logic  start;
    addr_t base_addr;
    len_t  word_count;
    logic  done;

    // Reader to buffer
    logic  push;
    data_t push_data;
    logic  not_full;

    // Buffer to writer
    logic  pop;
    data_t pop_data;
    logic  not_empty;

    // ----------------------------------------------------------
    // Input side
    // ----------------------------------------------------------
    dma_req_gate i_req_gate (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .req_valid_i    ( req_valid_i    ),
        .req_src_addr_i ( req_src_addr_i ),
        .req_len_i      ( req_len_i      ),
        .req_ready_o    ( req_ready_o    ),
        .rsp_valid_o    ( rsp_valid_o    ),
        .rsp_error_o    ( rsp_error_o    ),
        .rsp_ready_i    ( rsp_ready_i    ),
        .start_o        ( start          ),
        .base_addr_o    ( base_addr      ),
        .word_count_o   ( word_count     ),
        .done_i         ( done           ),
        .busy_o         ( busy_o         )
    );

    // ----------------------------------------------------------
    // Read path and decoupling
    // ----------------------------------------------------------
    dma_wb_reader i_wb_reader (
        .clk_i          ( clk_i      ),
        .rst_n_i        ( rst_n_i    ),
        .start_i        ( start      ),
        .base_addr_i    ( base_addr  ),
        .word_count_i   ( word_count ),
        .wb_cyc_o       ( wb_cyc_o   ),
        .wb_stb_o       ( wb_stb_o   ),
        .wb_adr_o       ( wb_adr_o   ),
        .wb_dat_i       ( wb_dat_i   ),
        .wb_ack_i       ( wb_ack_i   ),
        .buf_push_o     ( push       ),
        .buf_data_o     ( push_data  ),
        .buf_not_full_i ( not_full   )
    );

    dma_beat_buffer #(
        .BufferDepth ( BufferDepth )
    ) i_beat_buffer (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .push_i      ( push      ),
        .push_data_i ( push_data ),
        .not_full_o  ( not_full  ),
        .pop_i       ( pop       ),
        .pop_data_o  ( pop_data  ),
        .not_empty_o ( not_empty )
    );

    // ----------------------------------------------------------
    // Output side
    // ----------------------------------------------------------
    dma_stream_writer i_stream_writer (
        .clk_i           ( clk_i      ),
        .rst_n_i         ( rst_n_i    ),
        .start_i         ( start      ),
        .word_count_i    ( word_count ),
        .buf_pop_o       ( pop        ),
        .buf_data_i      ( pop_data   ),
        .buf_not_empty_i ( not_empty  ),
        .st_valid_o      ( st_valid_o ),
        .st_data_o       ( st_data_o  ),
        .st_last_o       ( st_last_o  ),
        .st_ready_i      ( st_ready_i ),
        .done_o          ( done       )
    );

endmodule

/* bench/tb_dma_models.svh */
// Included in the testbench module after clk, the wb_* signals, bus_rng and mismatch_count
`ifndef TB_DMA_MODELS_SVH
`define TB_DMA_MODELS_SVH

// ------------------------------------------------------------
// Random numbers and memory model
// ------------------------------------------------------------

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Source memory content, a hash over every address bit
function automatic data_t mem_word(input addr_t addr);
    return xorshift32(xorshift32({8'h5c, addr}) ^ 32'h9e37_79b9);
endfunction

// Reports a wrong value and counts it
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        mismatch_count++;
        $display("MISMATCH %s expected 0x%08h actual 0x%08h at %0t",
                 name, expected, actual, $time);
    end
endtask

// ------------------------------------------------------------
// Wishbone classic slave
// ------------------------------------------------------------

// Acks each strobe after 0 to 3 idle cycles and watches the held request
task automatic respond_bus();
    addr_t held_addr;
    int    delay;
    wb_ack = 1'b0;
    wb_dat = '0;
    forever begin
        @(negedge clk);
        // Ack lasts one cycle, the master drops stb right after it
        wb_ack = 1'b0;
        if (wb_cyc && wb_stb) begin
            held_addr = wb_adr;
            bus_rng   = xorshift32(bus_rng);
            delay     = int'(bus_rng % 4);
            repeat (delay) begin
                @(negedge clk);
                check_value("wb stb held", 32'd1, 32'(wb_stb));
                check_value("wb address held", 32'(held_addr), 32'(wb_adr));
            end
            wb_dat = mem_word(held_addr);
            wb_ack = 1'b1;
        end
    end
endtask

`endif

/* bench/tb_dma_backend.sv */
// Random requests, ack delays and back-pressure against a queue model; BufferDepth 4, aligned sources
`timescale 1ns/1ns

module tb_dma_backend
    import dma_pkg::*;
();

    localparam int unsigned NUM_REQUESTS   = 40;
    localparam int unsigned MAX_LEN        = 12;
    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED           = 32'hc71e;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_ready;
    addr_t req_src_addr;
    len_t  req_len;
    logic  rsp_valid;
    logic  rsp_error;
    logic  rsp_ready;
    logic  wb_cyc;
    logic  wb_stb;
    addr_t wb_adr;
    data_t wb_dat;
    logic  wb_ack;
    logic  st_valid;
    data_t st_data;
    logic  st_last;
    logic  st_ready;
    logic  busy;

    int          mismatch_count = 0;
    int          failure_count  = 0;
    bit          timed_out      = 1'b0;
    logic [31:0] stim_rng;
    logic [31:0] bus_rng;
    logic [31:0] bp_rng;

    // Expected beats and responses in arrival order
    data_t exp_data[$];
    bit    exp_last[$];
    int    exp_tag[$];
    bit    exp_err[$];

    // Transfer window as seen on the pins
    bit in_flight    = 1'b0;
    bit zero_pending = 1'b0;
    int rsp_seen     = 0;
    int beat_tag;

    rd_state_e rd_state;
    assign rd_state = UUT.i_wb_reader.state_q;

    `include "tb_dma_models.svh"

    dma_backend_top #(
        .BufferDepth ( 4 )
    ) UUT (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .req_valid_i    ( req_valid    ),
        .req_ready_o    ( req_ready    ),
        .req_src_addr_i ( req_src_addr ),
        .req_len_i      ( req_len      ),
        .rsp_valid_o    ( rsp_valid    ),
        .rsp_error_o    ( rsp_error    ),
        .rsp_ready_i    ( rsp_ready    ),
        .wb_cyc_o       ( wb_cyc       ),
        .wb_stb_o       ( wb_stb       ),
        .wb_adr_o       ( wb_adr       ),
        .wb_dat_i       ( wb_dat       ),
        .wb_ack_i       ( wb_ack       ),
        .st_valid_o     ( st_valid     ),
        .st_data_o      ( st_data      ),
        .st_last_o      ( st_last      ),
        .st_ready_i     ( st_ready     ),
        .busy_o         ( busy         )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        bus_rng = SEED ^ 32'h5a5a_0000;
        respond_bus();
    end

    // Stream and response back-pressure
    initial begin
        bp_rng    = SEED ^ 32'h0000_a5a5;
        st_ready  = 1'b0;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            bp_rng    = xorshift32(bp_rng);
            st_ready  = (bp_rng[3:0] > 4'd5);
            rsp_ready = bp_rng[8];
        end
    end

    // ------------------------------------------------------------
    // Pin monitor
    // ------------------------------------------------------------
    // Pins sampled just after the falling-edge drives, as the next rising edge sees them
    always begin
        @(negedge clk);
        #1;
        if (rst_n) begin
            check_value("busy during transfer", 32'(in_flight), 32'(busy));
            check_value("req ready when idle", 32'(!in_flight), 32'(req_ready));
            // Classic bus, cycle and strobe go together
            check_value("wb cyc with stb", 32'(wb_stb), 32'(wb_cyc));
            if (zero_pending) begin
                check_value("zero length no stb", 32'd0, 32'(wb_stb));
                check_value("zero length no beat", 32'd0, 32'(st_valid));
            end
            if (st_valid && st_ready) begin
                if (exp_data.size() == 0) begin
                    failure_count++;
                    $display("Stream beat 0x%08h arrived with no word expected", st_data);
                end else begin
                    beat_tag = exp_tag.pop_front();
                    check_value($sformatf("req %0d beat %0d data", beat_tag / 16, beat_tag % 16),
                                exp_data.pop_front(), st_data);
                    check_value($sformatf("req %0d beat %0d last", beat_tag / 16, beat_tag % 16),
                                32'(exp_last.pop_front()), 32'(st_last));
                end
            end
            // No response before every beat of its transfer
            if (rsp_valid) begin
                check_value("response after last beat", 32'd0, 32'(exp_data.size()));
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_err.size() == 0) begin
                    failure_count++;
                    $display("Response %0d arrived with no request outstanding", rsp_seen);
                end else begin
                    check_value($sformatf("response %0d error flag", rsp_seen),
                                32'(exp_err.pop_front()), 32'(rsp_error));
                end
                rsp_seen++;
                in_flight    = 1'b0;
                zero_pending = 1'b0;
            end
            if (req_valid && req_ready) begin
                in_flight    = 1'b1;
                zero_pending = (req_len == '0);
            end
        end
    end

    // Holds one request until taken, then loads its expected beats
    task automatic send_request(input int idx, input addr_t addr, input int len);
        int waited;
        waited = 0;
        @(negedge clk);
        req_valid    = 1'b1;
        req_src_addr = addr;
        req_len      = len_t'(len);
        // Ready high at a falling edge means the next rising edge takes the request
        while (!req_ready && !timed_out) begin
            if (waited == TIMEOUT_CYCLES) begin
                failure_count++;
                timed_out = 1'b1;
                $display("Timeout: request %0d was never accepted, reader in %s",
                         idx, rd_state.name());
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        if (!timed_out) begin
            @(posedge clk);
            @(negedge clk);
            req_valid = 1'b0;
            for (int i = 0; i < len; i++) begin
                exp_data.push_back(mem_word(addr + addr_t'(WORD_BYTES * i)));
                exp_last.push_back(i == len - 1);
                exp_tag.push_back(idx * 16 + i);
            end
            exp_err.push_back(len == 0);
        end
    endtask

    // Waits until the last response has been taken
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while ((in_flight || exp_err.size() != 0) && !timed_out) begin
            if (waited == TIMEOUT_CYCLES) begin
                failure_count++;
                timed_out = 1'b1;
                $display("Timeout: final response never came, %0d words still due, reader in %s",
                         exp_data.size(), rd_state.name());
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        if (exp_data.size() != 0) begin
            failure_count++;
            $display("%0d expected words never appeared on the stream", exp_data.size());
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        addr_t addr;
        int    len;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_src_addr = '0;
        req_len      = '0;
        stim_rng     = SEED;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("reset rsp_valid", 32'd0, 32'(rsp_valid));
        check_value("reset wb_cyc", 32'd0, 32'(wb_cyc));
        check_value("reset wb_stb", 32'd0, 32'(wb_stb));
        check_value("reset st_valid", 32'd0, 32'(st_valid));
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset req_ready", 32'd1, 32'(req_ready));
        for (int k = 0; k < NUM_REQUESTS && !timed_out; k++) begin
            stim_rng = xorshift32(stim_rng);
            // Roughly one zero length in six
            if (stim_rng % 6 == 0) begin
                len = 0;
            end else begin
                len = 1 + int'((stim_rng >> 8) % MAX_LEN);
            end
            stim_rng = xorshift32(stim_rng);
            addr     = stim_rng[ADDR_W-1:0] & ~addr_t'(WORD_BYTES - 1);
            send_request(k, addr, len);
            repeat (stim_rng[17:16]) @(negedge clk);
        end
        if (!timed_out) begin
            wait_drain();
        end
        $display("Errors: %0d (mismatches %0d, other failures %0d)",
                 mismatch_count + failure_count, mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+bench
logic/dma_pkg.sv
logic/dma_req_gate.sv
logic/dma_wb_reader.sv
logic/dma_beat_buffer.sv
logic/dma_stream_writer.sv
logic/dma_backend_top.sv
bench/tb_dma_backend.sv

/* Bender.yml */
package:
  name: dma_backend

sources:
  - target: any(rtl, test)
    files:
      - logic/dma_pkg.sv
      - logic/dma_req_gate.sv
      - logic/dma_wb_reader.sv
      - logic/dma_beat_buffer.sv
      - logic/dma_stream_writer.sv
      - logic/dma_backend_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_dma_backend.sv
